// ==== files.f ====
design/isaPkg.sv
design/ctrlPkg.sv
design/aluUnit.sv
design/shiftUnit.sv
design/regFile.sv
design/cpuControl.sv
design/cpuDatapath.sv
design/cpuCore.sv
tb/cpuCore_sva.sv
tb/cpuCoreTb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - design/isaPkg.sv
  - design/ctrlPkg.sv
  - design/aluUnit.sv
  - design/shiftUnit.sv
  - design/regFile.sv
  - design/cpuControl.sv
  - design/cpuDatapath.sv
  - design/cpuCore.sv
  - target: test
    files:
      - tb/cpuCore_sva.sv
      - tb/cpuCoreTb.sv

// ==== tb/cpuCoreTb.sv ====
// Memory answers reads one cycle late and never stalls; stores must land at 0x800 and above
`default_nettype none

module cpuCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    import isaPkg::*;

    localparam int unsigned resetCycles = 16;
    localparam int unsigned memWords = 1024;
    localparam logic [15:0] dataBase = 16'h0800;

    logic clk;
    logic arstN;
    logic [wordWidth-1:0] memRdData;
    memReq_t memReq;

    logic [wordWidth-1:0] mem [memWords];
    logic [wordWidth-1:0] refRegs [32];
    logic [wordWidth-1:0] expAddr [$];
    logic [wordWidth-1:0] expData [$];
    int unsigned progLen;
    int unsigned storeIdx = 0;
    int unsigned errCount = 0;
    int unsigned cycles = 0;
    int unsigned timeoutLimit;

    cpuCore cpuCore_inst (
        .clk      (clk),
        .arstN    (arstN),
        .memRdData(memRdData),
        .memReq   (memReq)
    );

    bind cpuCore cpuCoreSva cpuCoreSva_inst (
        .clk   (clk),
        .arstN (arstN),
        .memReq(memReq)
    );

    function automatic logic [31:0] encodeR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                            logic [4:0] shamt, logic [5:0] funct);
        return {opcodeRType, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                            logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic signedOverflow(longint sum);
        return (sum > 64'sd2147483647) || (sum < -64'sd2147483648);
    endfunction

    task automatic emitWord(logic [31:0] word);
        mem[progLen] = word;
        progLen++;
    endtask

    task automatic addImmediate(logic [4:0] rt, logic [4:0] rs, logic [15:0] imm);
        longint sum;
        emitWord(encodeI(opcodeAddi, rs, rt, imm));
        sum = longint'($signed(refRegs[rs])) + longint'($signed(imm));
        if (!signedOverflow(sum) && rt != 5'd0) begin
            refRegs[rt] = sum[31:0];
        end
    endtask

    task automatic addOrSub(logic [4:0] rd, logic [4:0] rs, logic [4:0] rt, logic isSub);
        longint a;
        longint b;
        longint sum;
        emitWord(encodeR(rs, rt, rd, 5'd0, isSub ? functSub : functAdd));
        a = longint'($signed(refRegs[rs]));
        b = longint'($signed(refRegs[rt]));
        sum = isSub ? a - b : a + b;
        // Overflowing results leave rd untouched
        if (!signedOverflow(sum) && rd != 5'd0) begin
            refRegs[rd] = sum[31:0];
        end
    endtask

    task automatic shiftByAmount(logic [4:0] rd, logic [4:0] rt, logic [4:0] shamt,
                                 logic [5:0] funct);
        emitWord(encodeR(5'd0, rt, rd, shamt, funct));
        if (rd != 5'd0) begin
            case (funct)
                functSll: refRegs[rd] = refRegs[rt] << shamt;
                functSrl: refRegs[rd] = refRegs[rt] >> shamt;
                default: refRegs[rd] = $signed(refRegs[rt]) >>> shamt;
            endcase
        end
    endtask

    // Base register is r0, so the address is the immediate itself
    task automatic storeWord(logic [4:0] rt);
        logic [15:0] imm;
        imm = dataBase + 16'(4 * expAddr.size());
        emitWord(encodeI(opcodeSw, 5'd0, rt, imm));
        expAddr.push_back(32'(imm));
        expData.push_back(refRegs[rt]);
    endtask

    task automatic buildProgram();
        for (int i = 0; i < memWords; i++) begin
            // Unknown opcode everywhere outside the program
            mem[i] = {6'b111_111, 26'(i)};
        end
        for (int r = 0; r < 32; r++) begin
            refRegs[r] = 'x;
        end
        refRegs[0] = '0;
        refRegs[stackPtrReg] = stackTop;
        progLen = 0;

        storeWord(5'd29);
        for (int r = 1; r <= 6; r++) begin
            addImmediate(5'(r), 5'd0, 16'($urandom));
            storeWord(5'(r));
        end
        addOrSub(5'd7, 5'd1, 5'd2, 1'b0);
        storeWord(5'd7);
        addOrSub(5'd8, 5'd3, 5'd4, 1'b1);
        storeWord(5'd8);
        shiftByAmount(5'd9, 5'd5, 5'($urandom_range(1, 31)), functSll);
        storeWord(5'd9);
        shiftByAmount(5'd10, 5'd6, 5'($urandom_range(1, 31)), functSrl);
        storeWord(5'd10);
        shiftByAmount(5'd11, 5'd1, 5'($urandom_range(1, 31)), functSra);
        storeWord(5'd11);

        // Overflow cases for add, sub and addi
        addImmediate(5'd12, 5'd0, 16'd1);
        storeWord(5'd12);
        shiftByAmount(5'd13, 5'd12, 5'd30, functSll);
        storeWord(5'd13);
        addImmediate(5'd14, 5'd0, 16'($urandom));
        storeWord(5'd14);
        addOrSub(5'd14, 5'd13, 5'd13, 1'b0);
        storeWord(5'd14);
        shiftByAmount(5'd16, 5'd12, 5'd31, functSll);
        storeWord(5'd16);
        addImmediate(5'd15, 5'd0, 16'($urandom));
        storeWord(5'd15);
        addOrSub(5'd15, 5'd16, 5'd12, 1'b1);
        storeWord(5'd15);
        addImmediate(5'd18, 5'd0, 16'hffff);
        shiftByAmount(5'd17, 5'd18, 5'd1, functSrl);
        storeWord(5'd17);
        addImmediate(5'd17, 5'd17, 16'd1);
        storeWord(5'd17);

        // Unknown opcode with r7 in its rt and rd fields
        emitWord({6'b010_101, 5'd1, 5'd7, 5'd7, 11'($urandom)});
        storeWord(5'd7);
        storeWord(5'd29);
    endtask

    task automatic checkStore();
        if (storeIdx >= expAddr.size()) begin
            $display("Unexpected store at time %0t to address %h", $time, memReq.addr);
            errCount++;
        end else begin
            assert (memReq.addr === expAddr[storeIdx]) else begin
                $display("[FAIL] %0t memReq.addr expected %h actual %h",
                         $time, expAddr[storeIdx], memReq.addr);
                errCount++;
            end
            assert (memReq.wrData === expData[storeIdx]) else begin
                $display("[FAIL] %0t memReq.wrData expected %h actual %h",
                         $time, expData[storeIdx], memReq.wrData);
                errCount++;
            end
            storeIdx++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Synchronous memory
    always @(posedge clk) begin
        if (memReq.read) begin
            memRdData <= mem[memReq.addr[11:2]];
        end
        if (memReq.write) begin
            mem[memReq.addr[11:2]] <= memReq.wrData;
        end
    end

    always @(negedge clk) begin
        if (arstN && memReq.write) begin
            checkStore();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeoutLimit) begin
            $display("Timeout after %0d cycles, %0d of %0d stores seen",
                     cycles, storeIdx, expAddr.size());
            $display("Errors: %0d store checks, %0d protocol assertions",
                     errCount, cpuCore_inst.cpuCoreSva_inst.failCount);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        arstN = 1'b0;
        memRdData = '0;
        void'($urandom(32'heff3d151));
        buildProgram();
        timeoutLimit = progLen * 8 + resetCycles + 100;
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        while (storeIdx < expAddr.size()) begin
            @(posedge clk);
        end
        // A few idle cycles to catch stray writes
        repeat (20) @(posedge clk);
        $display("Errors: %0d store checks, %0d protocol assertions",
                 errCount, cpuCore_inst.cpuCoreSva_inst.failCount);
        if (errCount == 0 && cpuCore_inst.cpuCoreSva_inst.failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/cpuCore_sva.sv ====
// Checks the memory port protocol only; store values are compared against the ISA model
`default_nettype none

module cpuCoreSva (
    input logic            clk,
    input logic            arstN,
    input isaPkg::memReq_t memReq
);
    timeunit 1ns;
    timeprecision 1ps;

    import isaPkg::*;

    int unsigned failCount = 0;
    logic readQ;
    logic seenFetch;
    logic [wordWidth-1:0] lastFetch;

    // Address of the previous fetch
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readQ <= 1'b0;
            seenFetch <= 1'b0;
            lastFetch <= '0;
        end else begin
            readQ <= memReq.read;
            if (memReq.read && !readQ) begin
                lastFetch <= memReq.addr;
                seenFetch <= 1'b1;
            end
        end
    end

    resetQuiet: assert property (@(posedge clk) !arstN |-> !memReq.read && !memReq.write)
        else begin
            $error("Memory strobe active during reset");
            failCount++;
        end

    // Stack init cycle comes first, then the fetch from address 0
    firstFetch: assert property (@(posedge clk) $rose(arstN) |->
                                 !memReq.read ##1 !memReq.read ##1
                                 (memReq.read && memReq.addr == '0))
        else begin
            $error("First fetch after reset not at address 0 two cycles after release");
            failCount++;
        end

    fetchStep: assert property (@(posedge clk) disable iff (!arstN)
                                $rose(memReq.read) && seenFetch |->
                                memReq.addr == lastFetch + 32'd4)
        else begin
            $error("[FAIL] %0t memReq.addr expected %h actual %h",
                   $time, $sampled(lastFetch) + 32'd4, $sampled(memReq.addr));
            failCount++;
        end

    readBurst: assert property (@(posedge clk) disable iff (!arstN)
                                $rose(memReq.read) |-> memReq.read[*3] ##1 !memReq.read)
        else begin
            $error("Fetch read not held for exactly three cycles");
            failCount++;
        end

    writePulse: assert property (@(posedge clk) disable iff (!arstN)
                                 memReq.write |=> !memReq.write)
        else begin
            $error("Memory write held longer than one cycle");
            failCount++;
        end

endmodule

`default_nettype wire

// ==== design/cpuCore.sv ====
// Single-issue core; the memory must answer a read one cycle later and never stall
`default_nettype none

module cpuCore (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [isaPkg::wordWidth-1:0] memRdData,
    output isaPkg::memReq_t              memReq
);
    import ctrlPkg::*;

    ctrlWord_t ctrl;
    dpStatus_t status;

    cpuControl cpuControl_inst (
        .clk   (clk),
        .arstN (arstN),
        .status(status),
        .ctrl  (ctrl)
    );

    cpuDatapath cpuDatapath_inst (
        .clk      (clk),
        .arstN    (arstN),
        .ctrl     (ctrl),
        .memRdData(memRdData),
        .status   (status),
        .memReq   (memReq)
    );

endmodule

`default_nettype wire

// ==== design/cpuDatapath.sv ====
// Follows the control selects blindly; memRdData is sampled only when irWrite is high
`default_nettype none

module cpuDatapath (
    input  logic                         clk,
    input  logic                         arstN,
    input  ctrlPkg::ctrlWord_t           ctrl,
    input  logic [isaPkg::wordWidth-1:0] memRdData,
    output ctrlPkg::dpStatus_t           status,
    output isaPkg::memReq_t              memReq
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [wordWidth-1:0] pc;
    instrWord_t ir;
    logic [wordWidth-1:0] regA;
    logic [wordWidth-1:0] regB;
    logic [wordWidth-1:0] aluOut;
    logic ovfQ;

    logic [wordWidth-1:0] rdDataA;
    logic [wordWidth-1:0] rdDataB;
    logic [wordWidth-1:0] aluA;
    logic [wordWidth-1:0] aluB;
    logic [wordWidth-1:0] aluResult;
    logic aluOverflow;
    logic [15:0] imm;
    logic [wordWidth-1:0] immExt;
    logic [wordWidth-1:0] shiftOut;
    logic [regAddrWidth-1:0] wrAddr;
    logic [wordWidth-1:0] wrData;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            ovfQ <= 1'b0;
        end else begin
            if (ctrl.pcWrite) begin
                pc <= aluResult;
            end
            if (ctrl.aluOutLoad) begin
                ovfQ <= aluOverflow;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            ir <= memRdData;
        end
        if (ctrl.abLoad) begin
            regA <= rdDataA;
            regB <= rdDataB;
        end
        if (ctrl.aluOutLoad) begin
            aluOut <= aluResult;
        end
    end

    // Sign-extended immediate for addi and sw
    assign imm = {ir.rd, ir.shamt, ir.funct};
    assign immExt = {{(wordWidth - 16){imm[15]}}, imm};

    always_comb begin
        aluA = (ctrl.srcA == srcAPc) ? pc : regA;
        case (ctrl.srcB)
            srcBFour: aluB = wordWidth'(4);
            srcBImm: aluB = immExt;
            default: aluB = regB;
        endcase
        case (ctrl.wrRegSel)
            wrRd: wrAddr = ir.rd;
            wrStack: wrAddr = stackPtrReg;
            default: wrAddr = ir.rt;
        endcase
        case (ctrl.wrDataSel)
            dataShift: wrData = shiftOut;
            dataStackTop: wrData = stackTop;
            default: wrData = aluOut;
        endcase
    end

    aluUnit aluUnit_inst (
        .a       (aluA),
        .b       (aluB),
        .op      (ctrl.aluOp),
        .result  (aluResult),
        .overflow(aluOverflow)
    );

    shiftUnit shiftUnit_inst (
        .clk   (clk),
        .arstN (arstN),
        .en    (ctrl.shiftEn),
        .op    (ctrl.shiftOp),
        .din   (regB),
        .amount(ir.shamt),
        .dout  (shiftOut)
    );

    regFile regFile_inst (
        .clk    (clk),
        .rdAddrA(ir.rs),
        .rdAddrB(ir.rt),
        .wrAddr (wrAddr),
        .wrEn   (ctrl.regWrite),
        .wrData (wrData),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB)
    );

    always_comb begin
        memReq.addr = (ctrl.memAddrSel == addrAluOut) ? aluOut : pc;
        memReq.wrData = regB;
        memReq.read = ctrl.memRead;
        memReq.write = ctrl.memWrite;
        status.opcode = ir.opcode;
        status.funct = ir.funct;
        status.overflow = ovfQ;
    end

endmodule

`default_nettype wire

// ==== design/cpuControl.sv ====
// Fixed-latency FSM with no stall input; memory data is assumed valid after the read cycles
`default_nettype none

module cpuControl (
    input  logic               clk,
    input  logic               arstN,
    input  ctrlPkg::dpStatus_t status,
    output ctrlPkg::ctrlWord_t ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    typedef enum logic [3:0] {
        stIdle,
        stStack,
        stFetch,
        stDecode,
        stAdd,
        stSub,
        stAddi,
        stSll,
        stSrl,
        stSra,
        stSw,
        stOverflow,
        stOpError
    } state_t;

    state_t state;
    state_t nextState;
    logic [1:0] count;
    logic [1:0] nextCount;
    ctrlWord_t ctrlQ;
    logic aluWriteback;

    // Control word for one cycle of a state, all strobes cleared by default
    function automatic ctrlWord_t wordFor(state_t st, logic [1:0] cnt);
        ctrlWord_t w;
        w = '0;
        case (st)
            stStack: begin
                w.regWrite = 1'b1;
                w.wrRegSel = wrStack;
                w.wrDataSel = dataStackTop;
            end
            stFetch: begin
                w.srcA = srcAPc;
                w.srcB = srcBFour;
                w.aluOp = aluAdd;
                w.memAddrSel = addrPc;
                if (cnt < 2'(fetchReadCycles)) begin
                    w.memRead = 1'b1;
                end else begin
                    w.irWrite = 1'b1;
                    w.pcWrite = 1'b1;
                end
            end
            stDecode: begin
                w.abLoad = 1'b1;
            end
            stAdd, stSub, stAddi: begin
                w.srcA = srcARegA;
                w.srcB = (st == stAddi) ? srcBImm : srcBRegB;
                w.aluOp = (st == stSub) ? aluSub : aluAdd;
                if (cnt == 2'd0) begin
                    w.aluOutLoad = 1'b1;
                end else begin
                    w.regWrite = 1'b1;
                    w.wrRegSel = (st == stAddi) ? wrRt : wrRd;
                    w.wrDataSel = dataAluOut;
                end
            end
            stSll, stSrl, stSra: begin
                if (cnt == 2'd0) begin
                    w.shiftEn = 1'b1;
                    w.shiftOp = shiftLoad;
                end else if (cnt == 2'd1) begin
                    w.shiftEn = 1'b1;
                    w.shiftOp = (st == stSll) ? shiftLeft :
                                (st == stSrl) ? shiftRightLogic : shiftRightArith;
                end else begin
                    w.regWrite = 1'b1;
                    w.wrRegSel = wrRd;
                    w.wrDataSel = dataShift;
                end
            end
            stSw: begin
                w.srcA = srcARegA;
                w.srcB = srcBImm;
                w.aluOp = aluAdd;
                if (cnt == 2'd0) begin
                    w.aluOutLoad = 1'b1;
                end else begin
                    w.memWrite = 1'b1;
                    w.memAddrSel = addrAluOut;
                end
            end
            default: begin
            end
        endcase
        return w;
    endfunction

    always_comb begin
        nextState = state;
        nextCount = count + 2'd1;
        case (state)
            stFetch: begin
                if (count == 2'(fetchReadCycles)) begin
                    nextState = stDecode;
                    nextCount = '0;
                end
            end
            stDecode: begin
                nextCount = '0;
                nextState = stOpError;
                case (status.opcode)
                    opcodeRType: begin
                        case (status.funct)
                            functAdd: nextState = stAdd;
                            functSub: nextState = stSub;
                            functSll: nextState = stSll;
                            functSrl: nextState = stSrl;
                            functSra: nextState = stSra;
                            default: nextState = stOpError;
                        endcase
                    end
                    opcodeAddi: nextState = stAddi;
                    opcodeSw: nextState = stSw;
                    default: nextState = stOpError;
                endcase
            end
            stAdd, stSub, stAddi: begin
                if (count == 2'd1) begin
                    nextState = status.overflow ? stOverflow : stFetch;
                    nextCount = '0;
                end
            end
            stSll, stSrl, stSra: begin
                if (count == 2'd2) begin
                    nextState = stFetch;
                    nextCount = '0;
                end
            end
            stSw: begin
                if (count == 2'd1) begin
                    nextState = stFetch;
                    nextCount = '0;
                end
            end
            stIdle: begin
                nextState = stStack;
                nextCount = '0;
            end
            default: begin
                // Stack init, overflow and opcode error all return to fetch
                nextState = stFetch;
                nextCount = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            count <= '0;
            ctrlQ <= '0;
        end else begin
            state <= nextState;
            count <= nextCount;
            ctrlQ <= wordFor(nextState, nextCount);
        end
    end

    // Overflow flag only settles together with ALUOut, so the writeback is masked here
    assign aluWriteback = (state == stAdd || state == stSub || state == stAddi) &&
                          (count == 2'd1);

    always_comb begin
        ctrl = ctrlQ;
        ctrl.regWrite = ctrlQ.regWrite & ~(aluWriteback & status.overflow);
    end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
// No reset on the array; register 0 always reads zero and ignores writes
`default_nettype none

module regFile (
    input  logic                            clk,
    input  logic [isaPkg::regAddrWidth-1:0] rdAddrA,
    input  logic [isaPkg::regAddrWidth-1:0] rdAddrB,
    input  logic [isaPkg::regAddrWidth-1:0] wrAddr,
    input  logic                            wrEn,
    input  logic [isaPkg::wordWidth-1:0]    wrData,
    output logic [isaPkg::wordWidth-1:0]    rdDataA,
    output logic [isaPkg::wordWidth-1:0]    rdDataB
);
    import isaPkg::*;

    logic [wordWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge clk) begin
        if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// ==== design/shiftUnit.sv ====
// Holds its value when en is low; a shift always acts on the previously loaded word
`default_nettype none

module shiftUnit (
    input  logic                                 clk,
    input  logic                                 arstN,
    input  logic                                 en,
    input  ctrlPkg::shiftOp_t                    op,
    input  logic [isaPkg::wordWidth-1:0]         din,
    input  logic [$clog2(isaPkg::wordWidth)-1:0] amount,
    output logic [isaPkg::wordWidth-1:0]         dout
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [wordWidth-1:0] shiftQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            shiftQ <= '0;
        end else if (en) begin
            case (op)
                shiftLoad: shiftQ <= din;
                shiftLeft: shiftQ <= shiftQ << amount;
                shiftRightLogic: shiftQ <= shiftQ >> amount;
                shiftRightArith: shiftQ <= $signed(shiftQ) >>> amount;
                default: shiftQ <= shiftQ;
            endcase
        end
    end

    assign dout = shiftQ;

endmodule

`default_nettype wire

// ==== design/aluUnit.sv ====
// Combinational add/subtract; overflow is only meaningful for signed operands
`default_nettype none

module aluUnit (
    input  logic [isaPkg::wordWidth-1:0] a,
    input  logic [isaPkg::wordWidth-1:0] b,
    input  ctrlPkg::aluOp_t              op,
    output logic [isaPkg::wordWidth-1:0] result,
    output logic                         overflow
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [wordWidth-1:0] bEff;
    logic carryIn;

    // Subtract as a + ~b + 1
    always_comb begin
        carryIn = (op == aluSub);
        bEff = carryIn ? ~b : b;
        result = a + bEff + wordWidth'(carryIn);
        // Same operand signs but a different result sign
        overflow = (a[wordWidth-1] == bEff[wordWidth-1]) &&
                   (result[wordWidth-1] != a[wordWidth-1]);
    end

endmodule

`default_nettype wire

// ==== design/ctrlPkg.sv ====
// Select encodings are only meaningful together with the strobes of the same control word
`default_nettype none

package ctrlPkg;

    // Cycles with memRead high before the IR loads
    localparam int unsigned fetchReadCycles = 3;

    typedef enum logic [1:0] {aluAdd, aluSub} aluOp_t;

    typedef enum logic {srcAPc, srcARegA} srcA_t;

    typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm} srcB_t;

    typedef enum logic {addrPc, addrAluOut} memAddrSel_t;

    typedef enum logic [1:0] {wrRt, wrRd, wrStack} wrRegSel_t;

    typedef enum logic [1:0] {dataAluOut, dataShift, dataStackTop} wrDataSel_t;

    typedef enum logic [1:0] {
        shiftLoad,
        shiftLeft,
        shiftRightLogic,
        shiftRightArith
    } shiftOp_t;

    typedef struct packed {
        logic pcWrite;
        logic irWrite;
        logic abLoad;
        logic aluOutLoad;
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic shiftEn;
        aluOp_t aluOp;
        srcA_t srcA;
        srcB_t srcB;
        memAddrSel_t memAddrSel;
        wrRegSel_t wrRegSel;
        wrDataSel_t wrDataSel;
        shiftOp_t shiftOp;
    } ctrlWord_t;

    // Overflow is the registered flag that travels with ALUOut
    typedef struct packed {
        logic [5:0] opcode;
        logic [5:0] funct;
        logic overflow;
    } dpStatus_t;

endpackage

`default_nettype wire

// ==== design/isaPkg.sv ====
// Keeps only the add, sub, addi, sll, srl, sra and sw encodings; any other code decodes as an error
`default_nettype none

package isaPkg;

    localparam int unsigned wordWidth = 32;
    localparam int unsigned regAddrWidth = 5;

    // Opcodes
    localparam logic [5:0] opcodeRType = 6'b000_000;
    localparam logic [5:0] opcodeAddi = 6'b001_000;
    localparam logic [5:0] opcodeSw = 6'b101_011;

    // R-type funct codes
    localparam logic [5:0] functAdd = 6'b100_000;
    localparam logic [5:0] functSub = 6'b100_010;
    localparam logic [5:0] functSll = 6'b000_000;
    localparam logic [5:0] functSrl = 6'b000_010;
    localparam logic [5:0] functSra = 6'b000_011;

    // Stack pointer gets this value right after reset
    localparam logic [regAddrWidth-1:0] stackPtrReg = 5'd29;
    localparam logic [wordWidth-1:0] stackTop = 32'd227;

    // R-type layout; the I-type immediate is {rd, shamt, funct}
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrWord_t;

    // Read is a level, write a single-cycle pulse
    typedef struct packed {
        logic [wordWidth-1:0] addr;
        logic [wordWidth-1:0] wrData;
        logic read;
        logic write;
    } memReq_t;

endpackage

`default_nettype wire
